// File: flist.f
rtl/rob_pkg.sv
rtl/completion_queue.sv
rtl/rob.sv
rtl/retire_map.sv
rtl/rob_backend.sv
tb/rob_backend_assert.sv
tb/rob_backend_tb.sv

// File: run.sh
#!/bin/sh
# build and run the ROB back end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module rob_backend_tb \
    -f flist.f \
    -o rob_backend_sim

status=0
./obj_dir/rob_backend_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -qF '** FAIL **' sim.log || [ "$status" -ne 0 ]; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// File: tb/rob_backend_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rob_backend_tb import rob_pkg::*; ();

    localparam int rob_size    = 16;
    localparam int alert_depth = 2;
    localparam int limit       = 2000;   // about four times the stimulus length

    typedef struct packed {
        rob_entry_t ent;
        robn_t      robn;
        logic       bad;   // mispredicted branch
    } exp_t;

    logic                                  clock;
    logic                                  reset;
    rob_issue_t                            issue;
    fu_result_t [num_fu-1:0]               fu_done;
    logic                                  almost_full;
    robn_t [issue_width-1:0]               tail_robn;
    rob_commit_t                           commit;
    logic                                  squash;
    logic [xlen-1:0]                       redirect_pc;
    logic [issue_width-1:0]                freed_valid;
    logic [issue_width-1:0][prn_width-1:0] freed_prn;
    logic                                  halted;

    exp_t                                  expected[$];   // program order
    robn_t                                 pending[$];    // issued, not yet completed
    logic [prn_width-1:0]                  model_map [32];
    logic [xlen-1:0]                       done_target [rob_size];
    int                                    done_cycle [rob_size];
    logic [issue_width-1:0]                exp_freed_valid;
    logic [issue_width-1:0][prn_width-1:0] exp_freed_prn;
    logic                                  exp_halted = 1'b0;
    int                                    model_tail = 0;   // slot of the next issued lane
    int                                    cycles = 0;
    int                                    errors = 0;
    int                                    commits = 0;
    int                                    squashes = 0;
    int                                    next_pc = 4096;
    logic                                  run_ended = 1'b0;

    rob_backend #(
        .rob_size    (rob_size),
        .alert_depth (alert_depth)
    ) i_rob_backend (.*);

    bind rob_backend rob_backend_assert i_rob_backend_assert (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= limit) begin
            $display("timeout, run stopped after %0d cycles", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    final begin
        if (!run_ended && cycles < limit) begin
            $display("run stopped before the tests finished");
            $display("** FAIL **");
        end
    end

    task automatic report_value(input string name, input logic [xlen-1:0] got,
                                input logic [xlen-1:0] want);
        $display("FAIL %s = %h, expected %h (cycle %0d)", name, got, want, cycles);
        errors++;
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at cycle %0d: %s", cycles, msg);
        errors++;
    endtask

    function automatic int random_kind();
        return (($urandom % 4) == 0) ? 1 : 0;   // some well predicted branches
    endfunction

    // one cycle of output checks against the model
    task automatic check_cycle();
        exp_t e;
        @(negedge clock);
        assert (freed_valid == exp_freed_valid)
            else report_value("freed_valid", xlen'(freed_valid), xlen'(exp_freed_valid));
        for (int i = 0; i < issue_width; i++) begin
            if (exp_freed_valid[i]) begin
                assert (freed_prn[i] == exp_freed_prn[i])
                    else report_value("freed_prn", xlen'(freed_prn[i]), xlen'(exp_freed_prn[i]));
            end
        end
        for (int i = 0; i < issue_width; i++) begin
            assert (tail_robn[i] == robn_t'((model_tail + i) % rob_size))
                else report_value("tail_robn", xlen'(tail_robn[i]),
                                  xlen'((model_tail + i) % rob_size));
        end
        assert (halted == exp_halted) else report_value("halted", xlen'(halted), xlen'(exp_halted));
        assert (almost_full == (expected.size() > rob_size - alert_depth))
            else report_value("almost_full", xlen'(almost_full), xlen'(!almost_full));
        exp_freed_valid = '0;
        if (squash) begin
            squashes++;
            assert (expected.size() != 0 && expected[0].bad)
                else report_error("squash without a mispredicted branch at the head");
            if (expected.size() != 0) begin
                assert (redirect_pc == expected[0].ent.resolve_target)
                    else report_value("redirect_pc", redirect_pc, expected[0].ent.resolve_target);
            end
            expected.delete();   // younger work is gone
            pending.delete();
            model_tail = 0;
        end
        for (int i = 0; i < issue_width; i++) begin
            if (commit.valid[i]) begin
                assert (expected.size() != 0) else report_error("commit with nothing outstanding");
                if (expected.size() != 0) begin
                    e = expected.pop_front();
                    assert (commit.entries[i].pc == e.ent.pc)
                        else report_value("commit.pc", commit.entries[i].pc, e.ent.pc);
                    assert (commit.entries[i].dest_prn == e.ent.dest_prn)
                        else report_value("commit.dest_prn", xlen'(commit.entries[i].dest_prn),
                                          xlen'(e.ent.dest_prn));
                    assert (commit.entries[i].dest_arn == e.ent.dest_arn)
                        else report_value("commit.dest_arn", xlen'(commit.entries[i].dest_arn),
                                          xlen'(e.ent.dest_arn));
                    assert (!e.bad) else report_error("mispredicted branch committed");
                    assert (cycles >= done_cycle[e.robn] + 2)
                        else report_error("instruction committed before its completion");
                    exp_freed_valid[i] = 1'b1;
                    exp_freed_prn[i]   = model_map[e.ent.dest_arn];   // lane 1 sees lane 0
                    model_map[e.ent.dest_arn] = e.ent.dest_prn;
                    if (e.ent.halt) begin
                        exp_halted = 1'b1;
                    end
                    commits++;
                end
            end
        end
    endtask

    task automatic issue_lane(input int lane, input int kind, input logic accept);
        exp_t  e;
        robn_t r;
        r = robn_t'(model_tail);
        e = '0;
        e.ent.pc             = next_pc;
        e.ent.dest_arn       = arn_width'($urandom % 4);   // few registers, lanes often collide
        e.ent.dest_prn       = prn_width'($urandom);
        e.ent.cond_branch    = (kind == 1 || kind == 2);
        e.ent.predict_taken  = 1'b1;
        e.ent.predict_target = e.ent.pc + 32'h40;
        e.ent.resolve_target = (kind == 2) ? e.ent.pc + 32'h80 : e.ent.predict_target;
        e.ent.halt           = (kind == 3);
        e.robn               = r;
        e.bad                = (kind == 2);
        issue.valid[lane]    = 1'b1;
        issue.entries[lane]  = e.ent;
        if (accept) begin
            next_pc += 4;
            model_tail = (model_tail + 1) % rob_size;
            done_target[r] = e.ent.resolve_target;
            done_cycle[r]  = limit;   // not completed yet
            expected.push_back(e);
            pending.push_back(r);
        end
    endtask

    task automatic drive_completion(input int slot, input robn_t r);
        fu_done[slot] = '{done: 1'b1, robn: r, branch_taken: 1'b1, target_addr: done_target[r]};
        done_cycle[r] = cycles;
    endtask

    // kind 0 plain, 1 good branch, 2 mispredicted branch, 3 halt
    task automatic step(input int n_issue, input int kind0, input int kind1, input int max_done);
        int    pick;
        robn_t r;
        logic  accept;
        check_cycle();
        issue   = '0;
        fu_done = '0;
        for (int u = 0; u < max_done && pending.size() != 0; u++) begin
            pick = int'($urandom % pending.size());   // random completion order
            r    = pending[pick];
            pending.delete(pick);
            drive_completion(u, r);
        end
        accept = !almost_full && !squash;
        for (int i = 0; i < n_issue; i++) begin
            issue_lane(i, (i == 0) ? kind0 : kind1, accept);
        end
    endtask

    initial begin
        robn_t [issue_width-1:0] held;
        robn_t                   young_robn;
        robn_t                   late_robn;
        void'($urandom(73));
        reset           = 1'b1;
        issue           = '0;
        fu_done         = '0;
        exp_freed_valid = '0;
        exp_freed_prn   = '0;
        for (int r = 0; r < 32; r++) begin
            model_map[r] = prn_width'(r);   // identity after reset
        end
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        assert (tail_robn[0] == 0 && tail_robn[1] == 1 && !almost_full && !halted
                && commit.valid == '0 && !squash && freed_valid == '0)
            else report_error("outputs not idle after reset");

        for (int n = 0; n < 300; n++) begin
            step(int'($urandom % 3), random_kind(), random_kind(), int'($urandom % 4));
        end
        while (expected.size() != 0) begin
            step(0, 0, 0, 3);
        end

        // fill with no completions, then offer more while full
        while (!almost_full) begin
            step(2, 0, 0, 0);
        end
        held = tail_robn;
        step(2, 0, 0, 0);
        step(0, 0, 0, 0);
        assert (tail_robn == held) else report_value("tail_robn", xlen'(tail_robn), xlen'(held));
        while (expected.size() != 0) begin
            step(0, 0, 0, 3);
        end

        // mispredict behind one plain entry, one younger entry done first
        step(2, 0, 2, 0);
        step(2, 0, 0, 0);
        late_robn  = pending.pop_back();
        young_robn = pending.pop_back();
        step(0, 0, 0, 0);
        drive_completion(0, young_robn);
        while (expected.size() != 0) begin
            step(0, 0, 0, 2);   // plain entry and branch finish together
        end
        drive_completion(0, late_robn);   // reaches the queue in the squash cycle
        step(0, 0, 0, 0);
        assert (tail_robn[0] == 0 && tail_robn[1] == 1)
            else report_value("tail_robn", xlen'(tail_robn), 32'h10);
        step(2, 0, 0, 3);
        while (expected.size() != 0) begin
            step(0, 0, 0, 3);
        end

        step(1, 3, 0, 0);
        while (expected.size() != 0) begin
            step(0, 0, 0, 1);
        end
        repeat (3) step(0, 0, 0, 0);
        assert (squashes == 1) else report_error("mispredicted branch did not squash exactly once");

        run_ended = 1'b1;
        $display("%0d commits, %0d squashes, %0d errors", commits, squashes, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/rob_backend_assert.sv
`timescale 1ns/1ps
`default_nettype none

module rob_backend_assert import rob_pkg::*; (
    input wire logic                       clock,
    input wire logic                       reset,
    input wire rob_commit_t                commit,
    input wire logic                       squash,
    input wire logic                       halted,
    input wire fu_result_t [cdb_width-1:0] cdb
);

    logic [cdb_width-1:0] cdb_done;

    always_comb begin
        for (int c = 0; c < cdb_width; c++) begin
            cdb_done[c] = cdb[c].done;
        end
    end

    squash_alone: assert property (@(posedge clock) disable iff (reset)
        !(squash && commit.valid != '0)) else $error("squash raised together with a commit");

    lane_order: assert property (@(posedge clock) disable iff (reset)
        !(commit.valid[1] && !commit.valid[0])) else $error("commit lane 1 valid without lane 0");

    halted_sticky: assert property (@(posedge clock) disable iff (reset)
        $past(halted) |-> halted) else $error("halted fell outside reset");

    // queue flushed, so nothing left to broadcast
    cdb_quiet: assert property (@(posedge clock) disable iff (reset)
        $past(squash) |-> cdb_done == '0) else $error("cdb active in the cycle after squash");

endmodule

`default_nettype wire

// File: rtl/rob_backend.sv
`timescale 1ns/1ps
`default_nettype none

module rob_backend import rob_pkg::*; #(
    parameter int rob_size    = 16,
    parameter int alert_depth = issue_width
) (
    input  wire logic                             clock,
    input  wire logic                             reset,
    input  wire rob_issue_t                       issue,
    input  wire fu_result_t [num_fu-1:0]          fu_done,
    output logic                                  almost_full,
    output robn_t [issue_width-1:0]               tail_robn,
    output rob_commit_t                           commit,
    output logic                                  squash,
    output logic [xlen-1:0]                       redirect_pc,
    output logic [issue_width-1:0]                freed_valid,
    output logic [issue_width-1:0][prn_width-1:0] freed_prn,
    output logic                                  halted
);

    localparam int queue_depth = rob_size;   // one pending result per entry at most

    fu_result_t [cdb_width-1:0] cdb;

    completion_queue #(
        .queue_depth (queue_depth)
    ) i_completion_queue (
        .clock   (clock),
        .reset   (reset),
        .fu_done (fu_done),
        .squash  (squash),
        .cdb     (cdb)
    );

    rob #(
        .rob_size    (rob_size),
        .alert_depth (alert_depth)
    ) i_rob (
        .clock       (clock),
        .reset       (reset),
        .issue       (issue),
        .cdb         (cdb),
        .almost_full (almost_full),
        .tail_robn   (tail_robn),
        .commit      (commit),
        .squash      (squash),
        .redirect_pc (redirect_pc)
    );

    retire_map i_retire_map (
        .clock       (clock),
        .reset       (reset),
        .commit      (commit),
        .freed_valid (freed_valid),
        .freed_prn   (freed_prn),
        .halted      (halted)
    );

endmodule

`default_nettype wire

// File: rtl/retire_map.sv
`timescale 1ns/1ps
`default_nettype none

module retire_map import rob_pkg::*; (
    input  wire logic                               clock,
    input  wire logic                               reset,
    input  wire rob_commit_t                        commit,
    output logic [issue_width-1:0]                  freed_valid,
    output logic [issue_width-1:0][prn_width-1:0]   freed_prn,
    output logic                                    halted
);

    localparam int num_arch = 2 ** arn_width;

    logic [num_arch-1:0][prn_width-1:0]    arch_map;
    logic [num_arch-1:0][prn_width-1:0]    next_map;
    logic [issue_width-1:0][prn_width-1:0] next_freed_prn;
    logic                                  next_halted;

    always_comb begin
        next_map       = arch_map;
        next_freed_prn = '0;
        next_halted    = halted;

        // lane order, so lane 1 frees what lane 0 just wrote
        for (int i = 0; i < issue_width; i++) begin
            if (commit.valid[i]) begin
                next_freed_prn[i] = next_map[commit.entries[i].dest_arn];
                next_map[commit.entries[i].dest_arn] = commit.entries[i].dest_prn;
                if (commit.entries[i].halt) begin
                    next_halted = 1'b1;   // sticky until reset
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int r = 0; r < num_arch; r++) begin
                arch_map[r] <= prn_width'(r);   // identity map
            end
            freed_valid <= '0;
            halted      <= 1'b0;
        end else begin
            arch_map    <= next_map;
            freed_valid <= commit.valid;
            halted      <= next_halted;
        end
    end

    always_ff @(posedge clock) begin
        freed_prn <= next_freed_prn;
    end

endmodule

`default_nettype wire

// File: rtl/rob.sv
`timescale 1ns/1ps
`default_nettype none

module rob import rob_pkg::*; #(
    parameter int rob_size    = 16,
    parameter int alert_depth = issue_width
) (
    input  wire logic                       clock,
    input  wire logic                       reset,
    input  wire rob_issue_t                 issue,
    input  wire fu_result_t [cdb_width-1:0] cdb,
    output logic                            almost_full,
    output robn_t [issue_width-1:0]         tail_robn,
    output rob_commit_t                     commit,
    output logic                            squash,
    output logic [xlen-1:0]                 redirect_pc
);

    localparam int cnt_width = $clog2(rob_size + 1);

    rob_entry_t [rob_size-1:0] entries;
    rob_entry_t [rob_size-1:0] next_entries;
    robn_t                     head;
    robn_t                     next_head;
    robn_t                     tail;
    robn_t                     next_tail;
    logic [cnt_width-1:0]      count;
    logic [cnt_width-1:0]      next_count;

    assign almost_full = count > cnt_width'(rob_size - alert_depth);

    // slots the next issue lanes will land in
    always_comb begin
        for (int i = 0; i < issue_width; i++) begin
            tail_robn[i] = robn_t'((int'(tail) + i) % rob_size);
        end
    end

    always_comb begin
        robn_t                ptr;
        logic [cnt_width-1:0] left;
        logic                 blocked;
        robn_t                idx;

        commit       = '0;
        squash       = 1'b0;
        redirect_pc  = '0;
        next_entries = entries;
        ptr          = head;
        left         = count;
        blocked      = 1'b0;
        idx          = '0;

        // commit scan, stops at the first entry not ready
        for (int i = 0; i < issue_width; i++) begin
            if (!blocked && left != 0 && entries[ptr].executed) begin
                if (entries[ptr].success) begin
                    commit.valid[i]   = 1'b1;
                    commit.entries[i] = entries[ptr];
                    ptr  = robn_t'(wrap_incr(int'(ptr), rob_size));
                    left = left - 1'b1;
                end else begin
                    // a failed branch squashes only once it is the head,
                    // behind a lane that committed it waits a cycle
                    if (i == 0) begin
                        squash      = 1'b1;
                        redirect_pc = entries[ptr].resolve_target;
                    end
                    blocked = 1'b1;
                end
            end else begin
                blocked = 1'b1;
            end
        end

        next_head  = ptr;
        next_tail  = tail;
        next_count = left;

        if (squash) begin
            next_head  = '0;   // empty, younger work is gone
            next_tail  = '0;
            next_count = '0;
        end else begin
            if (!almost_full) begin
                for (int i = 0; i < issue_width; i++) begin
                    if (issue.valid[i]) begin
                        next_entries[next_tail]          = issue.entries[i];
                        next_entries[next_tail].executed = 1'b0;
                        next_entries[next_tail].success  = 1'b1;
                        next_tail  = robn_t'(wrap_incr(int'(next_tail), rob_size));
                        next_count = next_count + 1'b1;
                    end
                end
            end

            // cdb writeback and branch resolution
            for (int c = 0; c < cdb_width; c++) begin
                if (cdb[c].done) begin
                    idx = cdb[c].robn;
                    next_entries[idx].executed       = 1'b1;
                    next_entries[idx].resolve_taken  = cdb[c].branch_taken;
                    next_entries[idx].resolve_target = cdb[c].target_addr;
                    if (entries[idx].cond_branch || entries[idx].uncond_branch) begin
                        next_entries[idx].success =
                            (cdb[c].branch_taken == entries[idx].predict_taken) &&
                            (cdb[c].target_addr == entries[idx].predict_target);
                    end
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < rob_size; i++) begin
                entries[i] <= '{success: 1'b1, default: '0};
            end
        end else begin
            head    <= next_head;
            tail    <= next_tail;
            count   <= next_count;
            entries <= next_entries;
        end
    end

endmodule

`default_nettype wire

// File: rtl/completion_queue.sv
`timescale 1ns/1ps
`default_nettype none

module completion_queue import rob_pkg::*; #(
    parameter int queue_depth = 16
) (
    input  wire logic                    clock,
    input  wire logic                    reset,
    input  wire fu_result_t [num_fu-1:0] fu_done,
    input  wire logic                    squash,
    output fu_result_t [cdb_width-1:0]   cdb
);

    localparam int ptr_width = $clog2(queue_depth);
    localparam int cnt_width = $clog2(queue_depth + 1);

    typedef logic [ptr_width-1:0] ptr_t;

    fu_result_t [queue_depth-1:0] slots;
    fu_result_t [queue_depth-1:0] next_slots;
    fu_result_t [cdb_width-1:0]   next_cdb;
    ptr_t                         rd_ptr;
    ptr_t                         next_rd_ptr;
    ptr_t                         wr_ptr;
    ptr_t                         next_wr_ptr;
    logic [cnt_width-1:0]         count;
    logic [cnt_width-1:0]         next_count;

    always_comb begin
        next_slots  = slots;
        next_rd_ptr = rd_ptr;
        next_wr_ptr = wr_ptr;
        next_count  = count;
        next_cdb    = '0;

        // push in unit order
        for (int u = 0; u < num_fu; u++) begin
            if (fu_done[u].done) begin
                next_slots[next_wr_ptr] = fu_done[u];
                next_wr_ptr = ptr_t'(wrap_incr(int'(next_wr_ptr), queue_depth));
                next_count  = next_count + 1'b1;
            end
        end

        // oldest results go out on the cdb and leave the queue
        for (int c = 0; c < cdb_width; c++) begin
            if (next_count != 0) begin
                next_cdb[c] = next_slots[next_rd_ptr];
                next_rd_ptr = ptr_t'(wrap_incr(int'(next_rd_ptr), queue_depth));
                next_count  = next_count - 1'b1;
            end
        end

        if (squash) begin
            next_rd_ptr = '0;   // drops stored and incoming results
            next_wr_ptr = '0;
            next_count  = '0;
            next_cdb    = '0;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
            cdb    <= '0;
        end else begin
            rd_ptr <= next_rd_ptr;
            wr_ptr <= next_wr_ptr;
            count  <= next_count;
            cdb    <= next_cdb;
        end
    end

    always_ff @(posedge clock) begin
        slots <= next_slots;
    end

endmodule

`default_nettype wire

// File: rtl/rob_pkg.sv
`default_nettype none

package rob_pkg;

    localparam int issue_width = 2;   // issue and commit lanes
    localparam int cdb_width   = 2;   // completions broadcast per cycle
    localparam int num_fu      = 3;
    localparam int xlen        = 32;
    localparam int arn_width   = 5;
    localparam int prn_width   = 6;
    localparam int robn_width  = 4;   // up to 16 entries

    typedef logic [robn_width-1:0] robn_t;

    // one in-flight instruction
    typedef struct packed {
        logic                 executed;
        logic                 success;         // false on mispredict
        logic                 cond_branch;
        logic                 uncond_branch;
        logic                 predict_taken;
        logic                 resolve_taken;
        logic [xlen-1:0]      predict_target;
        logic [xlen-1:0]      resolve_target;
        logic [prn_width-1:0] dest_prn;
        logic [arn_width-1:0] dest_arn;
        logic [xlen-1:0]      pc;
        logic                 halt;
    } rob_entry_t;

    // issue packet, lanes written in order at the tail
    typedef struct packed {
        logic       [issue_width-1:0] valid;
        rob_entry_t [issue_width-1:0] entries;
    } rob_issue_t;

    // functional unit completion, also the cdb element
    typedef struct packed {
        logic            done;
        robn_t           robn;
        logic            branch_taken;
        logic [xlen-1:0] target_addr;
    } fu_result_t;

    // committed entries, lane 0 oldest
    typedef struct packed {
        logic       [issue_width-1:0] valid;
        rob_entry_t [issue_width-1:0] entries;
    } rob_commit_t;

    // circular pointer step for buffers of any depth
    function automatic int wrap_incr(int ptr, int depth);
        int nxt;
        nxt = ptr + 1;
        if (nxt >= depth) begin
            nxt = 0;
        end
        return nxt;
    endfunction

endpackage

`default_nettype wire
